/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_sqrt_unit
FILELIST  = compile.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) sqrt_params.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	elif ! grep -q "=== PASS ===" $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
+incdir+.
sqrt_pkg.sv
sqrt_core.sv
sqrt_round.sv
sqrt_unit.sv
tb_sqrt_unit.sv

/* sqrt_core.sv */
//**************************************************************************
// Bit-serial floor square root core
// Resolves one root bit per clock, gives root and remainder in 8 steps
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "sqrt_params.svh"

module sqrt_core
  import sqrt_pkg::*;
(
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 start,     // One-cycle strobe
  input  wire sqrt_req_t      req,
  output logic                busy,
  output logic                core_done, // One-cycle pulse, core_res valid
  output sqrt_core_res_t      core_res
);

  sqrt_state_e            state_q;
  logic [3:0]             i_q;       // Iterations completed
  logic [`SQRT_IN_W-1:0]  op_q;      // Latched operand
  sqrt_core_res_t         res_q;     // Partial root and remainder
  logic                   accept;

  logic [`SQRT_IN_W-1:0]   op_sh;
  logic [1:0]              pair;
  logic [`SQRT_REM_W-1:0]  rem_src;
  logic [`SQRT_ROOT_W-1:0] root_src;
  logic [`SQRT_REM_W+1:0]  cand;
  logic [`SQRT_REM_W+1:0]  trial;
  logic [`SQRT_REM_W+1:0]  diff;
  logic                    bit_nxt;
  logic [`SQRT_REM_W-1:0]  rem_nxt;
  logic [`SQRT_ROOT_W-1:0] root_nxt;

  assign accept = start && (state_q == ST_IDLE); // Dropped while busy
  assign busy   = (state_q == ST_ITER);

  // Next operand pair sits at the top after shifting out 2*i bits
  assign op_sh = op_q << {i_q, 1'b0};

  // One restoring step. The first step runs on the accepting edge
  always_comb begin
    if (state_q == ST_IDLE) begin
      rem_src  = '0;
      root_src = '0;
      pair     = req.operand[`SQRT_IN_W-1 -: 2];
    end else begin
      rem_src  = res_q.rem;
      root_src = res_q.root;
      pair     = op_sh[`SQRT_IN_W-1 -: 2];
    end

    cand  = {rem_src, pair};           // Bring down two bits
    trial = {1'b0, root_src, 2'b01};   // 4 * root + 1

    if (cand >= trial) begin
      diff    = cand - trial;
      bit_nxt = 1'b1;
    end else begin
      diff    = cand;
      bit_nxt = 1'b0;
    end

    // Remainder stays within 2 * root, so the top bits are zero
    rem_nxt  = diff[`SQRT_REM_W-1:0];
    root_nxt = {root_src[`SQRT_ROOT_W-2:0], bit_nxt};
  end

  // Control FSM and iteration counter
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= ST_IDLE;
      i_q       <= '0;
      core_done <= 1'b0;
    end else begin
      core_done <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            state_q <= ST_ITER;
            i_q     <= 4'd1;   // First bit resolved at accept
          end
        end
        ST_ITER: begin
          i_q <= i_q + 4'd1;
          if (i_q == 4'(`SQRT_ITERS - 1)) begin
            state_q   <= ST_IDLE;
            core_done <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Operand and partial result registers
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q       <= req.operand;
      res_q.mode <= req.mode;
    end
    if (accept || state_q == ST_ITER) begin
      res_q.root <= root_nxt;
      res_q.rem  <= rem_nxt;
    end
  end

  assign core_res = res_q;

  // Counter bounded by the iteration count
  a_cnt_max: assert property (@(posedge clk) disable iff (rst)
    i_q <= 4'(`SQRT_ITERS));

  // Finishing means all iterations ran
  a_cnt_done: assert property (@(posedge clk) disable iff (rst)
    core_done |-> (i_q == 4'(`SQRT_ITERS)));

  // Floor root brackets the operand
  a_root_bound: assert property (@(posedge clk) disable iff (rst)
    core_done |-> ((32'(res_q.root) * 32'(res_q.root) <= 32'(op_q)) &&
                   ((32'(res_q.root) + 32'd1) * (32'(res_q.root) + 32'd1) >
                    32'(op_q))));

  a_rem_bound: assert property (@(posedge clk) disable iff (rst)
    core_done |-> (10'(res_q.rem) <= {1'b0, res_q.root, 1'b0}));

  a_ctrl_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown({busy, core_done}));

endmodule

`default_nettype wire

/* sqrt_params.svh */
//**************************************************************************
// Width and iteration-count macros for the 16-bit square-root unit
//**************************************************************************

`ifndef SQRT_PARAMS_SVH
`define SQRT_PARAMS_SVH

// Operand width
`define SQRT_IN_W 16

// Floor root width, half the operand width
`define SQRT_ROOT_W 8

// Result width, one extra bit so that a rounded-up 256 fits
`define SQRT_OUT_W 9

// Remainder width, remainder is at most 2 * 255
`define SQRT_REM_W 9

// One root bit resolved per iteration
`define SQRT_ITERS 8

`endif

/* sqrt_pkg.sv */
//**************************************************************************
// Shared types of the square-root unit: mode and state enums,
// request and core result structs
//**************************************************************************

`default_nettype none

`include "sqrt_params.svh"

package sqrt_pkg;

  // Result mode selected per request
  typedef enum logic {
    MODE_FLOOR   = 1'b0,
    MODE_NEAREST = 1'b1
  } sqrt_mode_e;

  // Iterative core state
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_ITER = 1'b1
  } sqrt_state_e;

  // Request presented with the start strobe
  typedef struct packed {
    logic [`SQRT_IN_W-1:0] operand;
    sqrt_mode_e            mode;
  } sqrt_req_t;

  // Floor root and remainder, mode carried along for rounding
  typedef struct packed {
    logic [`SQRT_ROOT_W-1:0] root;
    logic [`SQRT_REM_W-1:0]  rem;
    sqrt_mode_e              mode;
  } sqrt_core_res_t;

endpackage

`default_nettype wire

/* sqrt_round.sv */
//**************************************************************************
// Rounding stage, registers the floor or nearest root of a core result
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "sqrt_params.svh"

module sqrt_round
  import sqrt_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    core_done,
  input  wire sqrt_core_res_t    core_res,
  output logic                   done,
  output logic [`SQRT_OUT_W-1:0] result   // Held until the next done
);

  logic [`SQRT_OUT_W-1:0] floor_ext;
  logic                   round_up;
  logic [`SQRT_OUT_W-1:0] round_val;

  assign floor_ext = {1'b0, core_res.root};

  // r > f means the root lies past f + 0.5
  assign round_up  = (core_res.mode == MODE_NEAREST) && (core_res.rem > floor_ext);
  assign round_val = floor_ext + {{(`SQRT_OUT_W-1){1'b0}}, round_up};

  always_ff @(posedge clk) begin
    if (rst) begin
      done   <= 1'b0;
      result <= '0;
    end else begin
      done <= core_done;
      if (core_done)
        result <= round_val;
    end
  end

  // 255 rounded up is the largest value
  a_result_max: assert property (@(posedge clk) disable iff (rst)
    result <= `SQRT_OUT_W'(256));

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    done |=> !done);

endmodule

`default_nettype wire

/* sqrt_unit.sv */
//**************************************************************************
// Square-root unit top level, core followed by the rounding stage
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "sqrt_params.svh"

module sqrt_unit
  import sqrt_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    start,   // Ignored while busy
  input  wire sqrt_req_t         req,
  output logic                   busy,
  output logic                   done,    // 9 cycles after accepted start
  output logic [`SQRT_OUT_W-1:0] result
);

  logic           core_done;
  sqrt_core_res_t core_res;

  // Floor root and remainder, 8 iterations
  sqrt_core core0 (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .req       (req),
    .busy      (busy),
    .core_done (core_done),
    .core_res  (core_res)
  );

  // One more cycle to apply the mode, overlaps the next operation
  sqrt_round round0 (
    .clk       (clk),
    .rst       (rst),
    .core_done (core_done),
    .core_res  (core_res),
    .done      (done),
    .result    (result)
  );

endmodule

`default_nettype wire

/* tb_sqrt_unit.sv */
//**************************************************************************
// Testbench for the square-root unit: corner and random requests,
// reference model with expected done times, watchdog
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

`include "sqrt_params.svh"

module tb_sqrt_unit
  import sqrt_pkg::*;
();

  localparam int NUM_CORNER  = 10;
  localparam int NUM_B2B     = 60;
  localparam int NUM_RAND    = 200;
  localparam int NUM_OPS     = NUM_CORNER + NUM_B2B + NUM_RAND;
  localparam int LATENCY     = 9;   // Accepting edge to done
  localparam int BUSY_CYCLES = 7;   // Edges that still see busy high
  localparam int WATCHDOG_NS = (NUM_OPS * 12 + 40) * 8;

  // Expected result and the cycle its done is due
  typedef struct packed {
    logic [`SQRT_OUT_W-1:0] value;
    logic [31:0]            due;
  } expect_t;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   start;
  sqrt_req_t              req;
  logic                   busy;
  logic                   done;
  logic [`SQRT_OUT_W-1:0] result;

  logic [31:0]            rng = 32'd74;
  logic [`SQRT_IN_W-1:0]  corners [5] = '{16'd0, 16'd1, 16'd225, 16'd65025, 16'd65535};
  expect_t                exp_q [$];
  logic [`SQRT_OUT_W-1:0] last_result = '0;
  int                     cycle = 0;
  int                     busy_until = -1;
  int                     accepted = 0;
  int                     dropped = 0;
  int                     overlapped = 0;
  int                     round_ups = 0;
  int                     round_downs = 0;

  sqrt_unit dut0 (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .req    (req),
    .busy   (busy),
    .done   (done),
    .result (result)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Largest r with r * r <= x, by plain search
  function automatic int floor_root(input int x);
    int r;
    r = 0;
    while ((r + 1) * (r + 1) <= x)
      r++;
    return r;
  endfunction

  function automatic int expected_result(input sqrt_req_t r);
    int x;
    int f;
    int rem;
    x   = int'(r.operand);
    f   = floor_root(x);
    rem = x - f * f;
    if (r.mode == MODE_NEAREST && rem > f)
      return f + 1;
    return f;
  endfunction

  // Biased toward squares and the rounding boundaries around them
  function automatic sqrt_req_t random_req();
    logic [31:0] rnd;
    logic [31:0] s;
    sqrt_req_t   r;
    rnd = xorshift32();
    s   = {24'd0, rnd[31:24]};
    case (rnd[18:17])
      2'd0:    r.operand = 16'(s * s);
      2'd1:    r.operand = 16'(s * s + s);          // Last round-down value
      2'd2:    r.operand = 16'(s * s + s + 32'd1);  // First round-up value
      default: r.operand = rnd[15:0];
    endcase
    r.mode = rnd[16] ? MODE_NEAREST : MODE_FLOOR;
    return r;
  endfunction

  task automatic stop_on_failure();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic idle_cycles(input int n);
    start <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  // Holds start until an edge sees busy low
  task automatic issue_op(input sqrt_req_t r);
    start <= 1'b1;
    req   <= r;
    @(posedge clk);
    while (busy)
      @(posedge clk);
    start <= 1'b0;
  endtask

  // Model and checks, on values sampled before the edge updates
  always @(posedge clk) begin
    int      f;
    int      e;
    expect_t ent;
    cycle++;
    if (!rst) begin
      if (exp_q.size() > 0 && exp_q[0].due == 32'(cycle)) begin
        assert (done) else begin
          $display("No done at cycle %0d, %0d cycles after an accepted start", cycle, LATENCY);
          stop_on_failure();
        end
        assert (result == exp_q[0].value) else begin
          $display("FAILED result: expected 0x%0h, got 0x%0h", exp_q[0].value, result);
          stop_on_failure();
        end
        last_result = exp_q[0].value;
        void'(exp_q.pop_front());
      end else begin
        assert (!done) else begin
          $display("Unexpected done at cycle %0d with no operation due", cycle);
          stop_on_failure();
        end
        assert (result == last_result) else begin  // Held between dones
          $display("FAILED result: expected 0x%0h, got 0x%0h", last_result, result);
          stop_on_failure();
        end
      end
      assert (busy == (cycle <= busy_until)) else begin
        $display("FAILED busy: expected 0x%0h, got 0x%0h", cycle <= busy_until, busy);
        stop_on_failure();
      end
      if (start) begin
        if (!busy) begin
          if (exp_q.size() > 0)
            overlapped++;    // Previous result still on its way out
          f         = floor_root(int'(req.operand));
          e         = expected_result(req);
          ent.value = `SQRT_OUT_W'(e);
          ent.due   = 32'(cycle + LATENCY);
          exp_q.push_back(ent);
          busy_until = cycle + BUSY_CYCLES;
          accepted++;
          if (req.mode == MODE_NEAREST) begin
            if (e > f)
              round_ups++;
            else
              round_downs++;
          end
        end else begin
          dropped++;
        end
      end
    end
  end

  initial begin
    sqrt_req_t r;
    int        gap;
    int        k;
    rst   <= 1'b1;
    start <= 1'b0;
    req   <= '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    idle_cycles(5);  // Quiet outputs before any start

    for (int i = 0; i < 5; i++) begin
      r.operand = corners[i];
      r.mode    = MODE_FLOOR;
      issue_op(r);
    end
    for (int i = 0; i < 5; i++) begin
      r.operand = corners[i];
      r.mode    = MODE_NEAREST;
      issue_op(r);
    end

    // Start held high, new request every cycle
    k = 0;
    while (k < NUM_B2B) begin
      start <= 1'b1;
      req   <= random_req();
      @(posedge clk);
      if (!busy)
        k++;
    end
    start <= 1'b0;

    for (k = 0; k < NUM_RAND; k++) begin
      gap = int'(xorshift32() % 32'd4);
      idle_cycles(gap);
      issue_op(random_req());
    end

    start <= 1'b0;
    while (exp_q.size() > 0)
      @(posedge clk);
    repeat (LATENCY + 3) @(posedge clk);  // Catch any late extra done

    assert (dropped > 0) else begin
      $display("No start was ever seen while busy");
      stop_on_failure();
    end
    assert (overlapped > 0) else begin
      $display("No start was accepted while a result was still in flight");
      stop_on_failure();
    end
    assert (round_ups > 0 && round_downs > 0) else begin
      $display("Nearest mode missed a round-up or a round-down case");
      stop_on_failure();
    end
    $display("Checked %0d operations, %0d starts dropped while busy", accepted, dropped);
    $display("=== PASS ===");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the test did not finish", WATCHDOG_NS);
    stop_on_failure();
  end

endmodule

`default_nettype wire
